// File: Bender.yml
package:
  name: axi4lite_dist

sources:
  - hw/axi_dist_pkg.sv
  - hw/axi_wr_join.sv
  - hw/axi_wr_route.sv
  - hw/axi_rd_route.sv
  - hw/axi_resp_return.sv
  - hw/axi4lite_dist.sv
  - target: test
    files:
      - testbench/axi_slave_model.sv
      - testbench/tb_axi4lite_dist.sv

// File: hw/axi4lite_dist.sv
//------------------------------
// AXI4-Lite 1:16 distributor
// Routes one master to sixteen slaves by addr[27:24]
//------------------------------
`timescale 1ns/10ps

module axi4lite_dist
(
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  axi_dist_pkg::mst_req_t  mst_req_i,
    output axi_dist_pkg::slv_resp_t mst_resp_o,
    output axi_dist_pkg::mst_req_t  slv_req_o  [axi_dist_pkg::NUM_PORTS],
    input  axi_dist_pkg::slv_resp_t slv_resp_i [axi_dist_pkg::NUM_PORTS]
);

    logic [axi_dist_pkg::NUM_PORTS-1:0] slv_awready;
    logic [axi_dist_pkg::NUM_PORTS-1:0] slv_wready;
    logic [axi_dist_pkg::NUM_PORTS-1:0] slv_arready;
    logic [axi_dist_pkg::NUM_PORTS-1:0] aw_req;
    logic [axi_dist_pkg::NUM_PORTS-1:0] w_req;
    logic [axi_dist_pkg::NUM_PORTS-1:0] ar_req;
    logic [axi_dist_pkg::NUM_PORTS-1:0] rready_vec;
    logic [axi_dist_pkg::NUM_PORTS-1:0] bready_vec;
    logic                               awready;
    logic                               wready;
    logic                               arready;
    logic                               aw_fwd;
    logic                               w_fwd;
    logic                               sel_open;
    logic                               sel_awready;
    logic                               sel_wready;
    logic                               wr_done;
    logic                               rd_done;
    axi_dist_pkg::port_idx_t            wr_sel;
    axi_dist_pkg::port_idx_t            rd_sel;
    axi_dist_pkg::slv_resp_t            resp_ret;

    //------------------------------
    // Write path
    //------------------------------
    axi_wr_join u_wr_join
    (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .awvalid_i     (mst_req_i.awvalid),
        .wvalid_i      (mst_req_i.wvalid),
        .sel_awready_i (sel_awready),
        .sel_wready_i  (sel_wready),
        .wr_done_i     (wr_done),
        .awready_o     (awready),
        .wready_o      (wready),
        .aw_fwd_o      (aw_fwd),
        .w_fwd_o       (w_fwd),
        .sel_open_o    (sel_open)
    );

    axi_wr_route u_wr_route
    (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .mst_req_i     (mst_req_i),
        .sel_open_i    (sel_open),
        .aw_fwd_i      (aw_fwd),
        .w_fwd_i       (w_fwd),
        .slv_awready_i (slv_awready),
        .slv_wready_i  (slv_wready),
        .aw_req_o      (aw_req),
        .w_req_o       (w_req),
        .wr_sel_o      (wr_sel),
        .sel_awready_o (sel_awready),
        .sel_wready_o  (sel_wready)
    );

    //------------------------------
    // Read path and responses
    //------------------------------
    axi_rd_route u_rd_route
    (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .arvalid_i     (mst_req_i.arvalid),
        .araddr_i      (mst_req_i.araddr),
        .slv_arready_i (slv_arready),
        .rd_done_i     (rd_done),
        .arready_o     (arready),
        .ar_req_o      (ar_req),
        .rd_sel_o      (rd_sel)
    );

    axi_resp_return u_resp_return
    (
        .rd_sel_i   (rd_sel),
        .wr_sel_i   (wr_sel),
        .slv_resp_i (slv_resp_i),
        .rready_i   (mst_req_i.rready),
        .bready_i   (mst_req_i.bready),
        .mst_resp_o (resp_ret),
        .rready_o   (rready_vec),
        .bready_o   (bready_vec),
        .rd_done_o  (rd_done),
        .wr_done_o  (wr_done)
    );

    // Per-port request structs, payload shared by all ports
    always_comb
    begin
        for (int k = 0; k < axi_dist_pkg::NUM_PORTS; k++)
        begin
            slv_awready[k] = slv_resp_i[k].awready;
            slv_wready[k]  = slv_resp_i[k].wready;
            slv_arready[k] = slv_resp_i[k].arready;

            slv_req_o[k]         = mst_req_i;
            slv_req_o[k].awvalid = aw_req[k];
            slv_req_o[k].wvalid  = w_req[k];
            slv_req_o[k].arvalid = ar_req[k];
            slv_req_o[k].bready  = bready_vec[k];
            slv_req_o[k].rready  = rready_vec[k];
        end
    end

    always_comb
    begin
        mst_resp_o         = resp_ret;
        mst_resp_o.awready = awready;
        mst_resp_o.wready  = wready;
        mst_resp_o.arready = arready;
    end

endmodule

// File: hw/axi_dist_pkg.sv
//------------------------------
// AXI4-Lite distributor types
// Widths, port count, channel structs and FSM states
//------------------------------
package axi_dist_pkg;

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int STRB_W    = 4;
    localparam int RESP_W    = 2;
    localparam int NUM_PORTS = 16;
    localparam int PORT_W    = 4;

    // Port select field is awaddr/araddr[27:24]
    localparam int SEL_LSB   = 24;

    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

    typedef logic [PORT_W-1:0] port_idx_t;

    //------------------------------
    // Channel bundles
    //------------------------------
    typedef struct packed {
        logic              awvalid;
        logic [ADDR_W-1:0] awaddr;
        logic              wvalid;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
        logic              bready;
        logic              arvalid;
        logic [ADDR_W-1:0] araddr;
        logic              rready;
    } mst_req_t;

    typedef struct packed {
        logic              awready;
        logic              wready;
        logic              bvalid;
        logic [RESP_W-1:0] bresp;
        logic              arready;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
        logic [RESP_W-1:0] rresp;
    } slv_resp_t;

    //------------------------------
    // Tracker states
    //------------------------------
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR_HELD,
        WR_DATA_HELD,
        WR_WAIT_RESP
    } wr_state_e;

    typedef enum logic {
        RD_IDLE,
        RD_WAIT_RESP
    } rd_state_e;

endpackage

// File: hw/axi_rd_route.sv
//------------------------------
// Read request router
// Owns the read tracker and the latched read port,
// fans AR out to the addressed slave
//------------------------------
`timescale 1ns/10ps

module axi_rd_route
(
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                arvalid_i,
    input  logic [axi_dist_pkg::ADDR_W-1:0]     araddr_i,
    input  logic [axi_dist_pkg::NUM_PORTS-1:0]  slv_arready_i,
    input  logic                                rd_done_i,
    output logic                                arready_o,
    output logic [axi_dist_pkg::NUM_PORTS-1:0]  ar_req_o,
    output axi_dist_pkg::port_idx_t             rd_sel_o
);

    axi_dist_pkg::rd_state_e state_q;
    axi_dist_pkg::rd_state_e state_d;
    axi_dist_pkg::port_idx_t sel_live;
    axi_dist_pkg::port_idx_t sel_q;
    logic                    rd_idle;
    logic                    ar_hs;

    assign rd_idle = (state_q == axi_dist_pkg::RD_IDLE);

    // Follow araddr until a read is accepted
    assign sel_live = rd_idle ?
                      araddr_i[axi_dist_pkg::SEL_LSB +: axi_dist_pkg::PORT_W] : sel_q;

    assign arready_o = rd_idle && slv_arready_i[sel_live];
    assign ar_hs     = arvalid_i && arready_o;

    always_comb
    begin
        ar_req_o = '0;
        ar_req_o[sel_live] = arvalid_i && rd_idle;
    end

    //------------------------------
    // Read tracker
    //------------------------------
    always_comb
    begin
        state_d = state_q;
        if (rd_idle && ar_hs)
            state_d = axi_dist_pkg::RD_WAIT_RESP;
        else if (!rd_idle && rd_done_i)
            state_d = axi_dist_pkg::RD_IDLE;
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            state_q <= axi_dist_pkg::RD_IDLE;
            sel_q   <= '0;
        end
        else
        begin
            state_q <= state_d;
            if (ar_hs)
                sel_q <= sel_live;
        end
    end

    assign rd_sel_o = sel_q;

    // Once a read is taken, nothing more is accepted until its R handshake
    a_rd_one_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
        ar_hs |=> (!arready_o && (ar_req_o == '0)) until rd_done_i);

endmodule

// File: hw/axi_resp_return.sv
//------------------------------
// Response return
// Muxes B and R from the latched ports back to the
// master and steers bready/rready to that port only
//------------------------------
`timescale 1ns/10ps

module axi_resp_return
(
    input  axi_dist_pkg::port_idx_t             rd_sel_i,
    input  axi_dist_pkg::port_idx_t             wr_sel_i,
    input  axi_dist_pkg::slv_resp_t             slv_resp_i [axi_dist_pkg::NUM_PORTS],
    input  logic                                rready_i,
    input  logic                                bready_i,
    output axi_dist_pkg::slv_resp_t             mst_resp_o,
    output logic [axi_dist_pkg::NUM_PORTS-1:0]  rready_o,
    output logic [axi_dist_pkg::NUM_PORTS-1:0]  bready_o,
    output logic                                rd_done_o,
    output logic                                wr_done_o
);

    //------------------------------
    // Response mux
    //------------------------------
    always_comb
    begin
        // Request-side readies are left low here
        mst_resp_o = '0;

        mst_resp_o.bvalid = slv_resp_i[wr_sel_i].bvalid;
        mst_resp_o.bresp  = slv_resp_i[wr_sel_i].bresp;

        mst_resp_o.rvalid = slv_resp_i[rd_sel_i].rvalid;
        mst_resp_o.rdata  = slv_resp_i[rd_sel_i].rdata;
        mst_resp_o.rresp  = slv_resp_i[rd_sel_i].rresp;
    end

    //------------------------------
    // Ready steering
    //------------------------------
    always_comb
    begin
        rready_o = '0;
        bready_o = '0;
        rready_o[rd_sel_i] = rready_i;
        bready_o[wr_sel_i] = bready_i;
    end

    // Master handshakes end the outstanding transactions
    assign rd_done_o = mst_resp_o.rvalid && rready_i;
    assign wr_done_o = mst_resp_o.bvalid && bready_i;

    // At most one slave sees each response ready
    a_ready_onehot: assert final ($onehot0(rready_o) && $onehot0(bready_o));

endmodule

// File: hw/axi_wr_join.sv
//------------------------------
// Write address/data join
// Tracks AW and W acceptance in either order and
// blocks new writes until the B handshake
//------------------------------
`timescale 1ns/10ps

module axi_wr_join
(
    input  logic clk_i,
    input  logic rst_i,
    input  logic awvalid_i,
    input  logic wvalid_i,
    input  logic sel_awready_i,
    input  logic sel_wready_i,
    input  logic wr_done_i,
    output logic awready_o,
    output logic wready_o,
    output logic aw_fwd_o,
    output logic w_fwd_o,
    output logic sel_open_o
);

    axi_dist_pkg::wr_state_e state_q;
    axi_dist_pkg::wr_state_e state_d;
    logic                    aw_hs;
    logic                    w_hs;

    // Address may go out until it has been taken
    assign aw_fwd_o = (state_q == axi_dist_pkg::WR_IDLE) ||
                      (state_q == axi_dist_pkg::WR_DATA_HELD);

    // Data needs a target, so a live or held address
    assign w_fwd_o  = ((state_q == axi_dist_pkg::WR_IDLE) && awvalid_i) ||
                      (state_q == axi_dist_pkg::WR_ADDR_HELD);

    // Port select tracks awaddr while the address is on offer
    assign sel_open_o = aw_fwd_o && awvalid_i;

    assign awready_o = aw_fwd_o && sel_awready_i;
    assign wready_o  = w_fwd_o && sel_wready_i;

    assign aw_hs = awvalid_i && awready_o;
    assign w_hs  = wvalid_i && wready_o;

    //------------------------------
    // Next state
    //------------------------------
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            axi_dist_pkg::WR_IDLE:
            begin
                if (aw_hs && w_hs)
                    state_d = axi_dist_pkg::WR_WAIT_RESP;
                else if (aw_hs)
                    state_d = axi_dist_pkg::WR_ADDR_HELD;
                else if (w_hs)
                    state_d = axi_dist_pkg::WR_DATA_HELD;
            end
            axi_dist_pkg::WR_ADDR_HELD:
            begin
                if (w_hs)
                    state_d = axi_dist_pkg::WR_WAIT_RESP;
            end
            axi_dist_pkg::WR_DATA_HELD:
            begin
                if (aw_hs)
                    state_d = axi_dist_pkg::WR_WAIT_RESP;
            end
            default:
            begin
                // B handshake closes the write
                if (wr_done_i)
                    state_d = axi_dist_pkg::WR_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            state_q <= axi_dist_pkg::WR_IDLE;
        else
            state_q <= state_d;
    end

    // No new address or data accepted while a response is owed
    a_wr_busy_blocked: assert property (@(posedge clk_i) disable iff (rst_i)
        (state_q == axi_dist_pkg::WR_WAIT_RESP) |-> !(awready_o || wready_o));

endmodule

// File: hw/axi_wr_route.sv
//------------------------------
// Write request router
// Decodes and latches the write port, fans AW/W out
// and returns the chosen port's readiness
//------------------------------
`timescale 1ns/10ps

module axi_wr_route
(
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  axi_dist_pkg::mst_req_t              mst_req_i,
    input  logic                                sel_open_i,
    input  logic                                aw_fwd_i,
    input  logic                                w_fwd_i,
    input  logic [axi_dist_pkg::NUM_PORTS-1:0]  slv_awready_i,
    input  logic [axi_dist_pkg::NUM_PORTS-1:0]  slv_wready_i,
    output logic [axi_dist_pkg::NUM_PORTS-1:0]  aw_req_o,
    output logic [axi_dist_pkg::NUM_PORTS-1:0]  w_req_o,
    output axi_dist_pkg::port_idx_t             wr_sel_o,
    output logic                                sel_awready_o,
    output logic                                sel_wready_o
);

    axi_dist_pkg::port_idx_t addr_port;
    axi_dist_pkg::port_idx_t sel_live;
    axi_dist_pkg::port_idx_t sel_q;

    assign addr_port = mst_req_i.awaddr[axi_dist_pkg::SEL_LSB +: axi_dist_pkg::PORT_W];

    // Live decode while open, held port once the address is taken
    assign sel_live = sel_open_i ? addr_port : sel_q;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            sel_q <= '0;
        else if (sel_open_i)
            sel_q <= addr_port;
    end

    assign wr_sel_o = sel_q;

    //------------------------------
    // Request fan-out
    //------------------------------
    always_comb
    begin
        aw_req_o = '0;
        w_req_o  = '0;
        aw_req_o[sel_live] = mst_req_i.awvalid && aw_fwd_i;
        w_req_o[sel_live]  = mst_req_i.wvalid && w_fwd_i;
    end

    // Readiness of the addressed slave only
    assign sel_awready_o = slv_awready_i[sel_live];
    assign sel_wready_o  = slv_wready_i[sel_live];

endmodule

// File: testbench/axi_slave_model.sv
//------------------------------
// AXI4-Lite slave model
// One data register, random ready and response delays
//------------------------------
`timescale 1ns/10ps

module axi_slave_model
(
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  axi_dist_pkg::port_idx_t port_id_i,
    input  axi_dist_pkg::mst_req_t  req_i,
    output axi_dist_pkg::slv_resp_t resp_o
);

    logic [axi_dist_pkg::DATA_W-1:0] data_q;
    logic [axi_dist_pkg::RESP_W-1:0] code;
    logic [1:0]                      aw_wait;
    logic [1:0]                      w_wait;
    logic [1:0]                      b_wait;
    logic [1:0]                      ar_wait;
    logic [1:0]                      r_wait;
    logic                            aw_done;
    logic                            w_done;
    logic                            ar_done;
    logic                            bvalid_q;
    logic                            rvalid_q;

    // Last port answers with an error
    assign code = (port_id_i == axi_dist_pkg::port_idx_t'(axi_dist_pkg::NUM_PORTS - 1)) ?
                  axi_dist_pkg::RESP_SLVERR : axi_dist_pkg::RESP_OKAY;

    always_comb
    begin
        resp_o         = '0;
        resp_o.awready = req_i.awvalid && !aw_done && (aw_wait == 2'd0);
        resp_o.wready  = req_i.wvalid && !w_done && (w_wait == 2'd0);
        resp_o.bvalid  = bvalid_q;
        resp_o.bresp   = code;
        resp_o.arready = req_i.arvalid && !ar_done && (ar_wait == 2'd0);
        resp_o.rvalid  = rvalid_q;
        resp_o.rdata   = data_q;
        resp_o.rresp   = code;
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            data_q   <= '0;
            aw_wait  <= 2'($urandom % 4);
            w_wait   <= 2'($urandom % 4);
            b_wait   <= 2'($urandom % 4);
            ar_wait  <= 2'($urandom % 4);
            r_wait   <= 2'($urandom % 4);
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
            ar_done  <= 1'b0;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end
        else
        begin
            //------------------------------
            // Write side
            //------------------------------
            if (resp_o.awready)
                aw_done <= 1'b1;
            else if (req_i.awvalid && !aw_done && (aw_wait != 2'd0))
                aw_wait <= aw_wait - 2'd1;

            if (resp_o.wready)
            begin
                w_done <= 1'b1;
                for (int b = 0; b < axi_dist_pkg::STRB_W; b++)
                begin
                    if (req_i.wstrb[b])
                        data_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
            else if (req_i.wvalid && !w_done && (w_wait != 2'd0))
                w_wait <= w_wait - 2'd1;

            if (aw_done && w_done && !bvalid_q)
            begin
                if (b_wait == 2'd0)
                    bvalid_q <= 1'b1;
                else
                    b_wait <= b_wait - 2'd1;
            end

            if (bvalid_q && req_i.bready)
            begin
                bvalid_q <= 1'b0;
                aw_done  <= 1'b0;
                w_done   <= 1'b0;
                aw_wait  <= 2'($urandom % 4);
                w_wait   <= 2'($urandom % 4);
                b_wait   <= 2'($urandom % 4);
            end

            //------------------------------
            // Read side
            //------------------------------
            if (resp_o.arready)
                ar_done <= 1'b1;
            else if (req_i.arvalid && !ar_done && (ar_wait != 2'd0))
                ar_wait <= ar_wait - 2'd1;

            if (ar_done && !rvalid_q)
            begin
                if (r_wait == 2'd0)
                    rvalid_q <= 1'b1;
                else
                    r_wait <= r_wait - 2'd1;
            end

            if (rvalid_q && req_i.rready)
            begin
                rvalid_q <= 1'b0;
                ar_done  <= 1'b0;
                ar_wait  <= 2'($urandom % 4);
                r_wait   <= 2'($urandom % 4);
            end
        end
    end

endmodule

// File: testbench/tb_axi4lite_dist.sv
//------------------------------
// AXI4-Lite distributor testbench
// Table-driven reads and writes over sixteen slave models
//------------------------------
`timescale 1ns/10ps

module tb_axi4lite_dist;

    typedef enum logic [1:0] {
        ORD_ADDR,
        ORD_DATA,
        ORD_BOTH
    } order_e;

    // One table row: a single transaction and its expected result
    typedef struct packed {
        logic        wr;
        order_e      order;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  rdy_dly;
        logic [31:0] exp_data;
        logic [1:0]  exp_resp;
    } vec_t;

    localparam logic [1:0] OKAY   = axi_dist_pkg::RESP_OKAY;
    localparam logic [1:0] SLVERR = axi_dist_pkg::RESP_SLVERR;
    localparam int NUM_VEC        = 14;
    localparam int TIMEOUT_CYCLES = NUM_VEC * 20;

    // Expected read data follows the byte strobe merge of earlier writes
    vec_t vectors [NUM_VEC] = '{
        '{1'b1, ORD_ADDR, 32'h0300_0010, 32'hA5A5_1234, 4'hF, 2'd0, 32'h0000_0000, OKAY},
        '{1'b0, ORD_ADDR, 32'h0300_0010, 32'h0,         4'h0, 2'd1, 32'hA5A5_1234, OKAY},
        '{1'b0, ORD_ADDR, 32'h0400_0000, 32'h0,         4'h0, 2'd0, 32'h0000_0000, OKAY},
        '{1'b1, ORD_DATA, 32'h0300_0010, 32'h0000_BEEF, 4'h3, 2'd2, 32'h0000_0000, OKAY},
        '{1'b0, ORD_ADDR, 32'h0300_0010, 32'h0,         4'h0, 2'd3, 32'hA5A5_BEEF, OKAY},
        '{1'b1, ORD_BOTH, 32'h0F00_0004, 32'h1111_2222, 4'hF, 2'd1, 32'h0000_0000, SLVERR},
        '{1'b0, ORD_ADDR, 32'h0F00_0004, 32'h0,         4'h0, 2'd2, 32'h1111_2222, SLVERR},
        '{1'b1, ORD_BOTH, 32'h0000_0000, 32'hCAFE_0000, 4'hC, 2'd0, 32'h0000_0000, OKAY},
        '{1'b0, ORD_ADDR, 32'h0000_0000, 32'h0,         4'h0, 2'd0, 32'hCAFE_0000, OKAY},
        '{1'b1, ORD_ADDR, 32'hF400_0008, 32'h1234_5678, 4'h1, 2'd3, 32'h0000_0000, OKAY},
        '{1'b0, ORD_ADDR, 32'h0400_0000, 32'h0,         4'h0, 2'd1, 32'h0000_0078, OKAY},
        '{1'b0, ORD_ADDR, 32'h0300_0010, 32'h0,         4'h0, 2'd0, 32'hA5A5_BEEF, OKAY},
        '{1'b1, ORD_DATA, 32'h0900_0000, 32'h8765_4321, 4'hF, 2'd1, 32'h0000_0000, OKAY},
        '{1'b0, ORD_ADDR, 32'h0900_0000, 32'h0,         4'h0, 2'd0, 32'h8765_4321, OKAY}
    };

    logic                    clk_i;
    logic                    rst_i;
    axi_dist_pkg::mst_req_t  mst_req;
    axi_dist_pkg::slv_resp_t mst_resp;
    axi_dist_pkg::mst_req_t  slv_req  [axi_dist_pkg::NUM_PORTS];
    axi_dist_pkg::slv_resp_t slv_resp [axi_dist_pkg::NUM_PORTS];
    axi_dist_pkg::port_idx_t cur_port;
    int                      cycle_cnt = 0;

    axi4lite_dist i_dut
    (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .mst_req_i  (mst_req),
        .mst_resp_o (mst_resp),
        .slv_req_o  (slv_req),
        .slv_resp_i (slv_resp)
    );

    for (genvar k = 0; k < axi_dist_pkg::NUM_PORTS; k++)
    begin : g_slave
        axi_slave_model i_slave
        (
            .clk_i     (clk_i),
            .rst_i     (rst_i),
            .port_id_i (axi_dist_pkg::port_idx_t'(k)),
            .req_i     (slv_req[k]),
            .resp_o    (slv_resp[k])
        );
    end

    initial
    begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    //------------------------------
    // Checker, monitor, timeout
    //------------------------------
    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp)
        begin
            $display("** Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Only the addressed port may ever see a request valid
    always @(posedge clk_i)
    begin
        if (!rst_i)
        begin
            for (int k = 0; k < axi_dist_pkg::NUM_PORTS; k++)
            begin
                if (k != cur_port)
                    check_value({slv_req[k].awvalid, slv_req[k].wvalid, slv_req[k].arvalid},
                                32'h0, $sformatf("request valid on unaddressed port %0d", k));
            end
            // Addressed port gets the master's address
            if (slv_req[cur_port].awvalid)
                check_value(slv_req[cur_port].awaddr, mst_req.awaddr,
                            "write address on the addressed port");
            if (slv_req[cur_port].arvalid)
                check_value(slv_req[cur_port].araddr, mst_req.araddr,
                            "read address on the addressed port");
        end
    end

    always @(posedge clk_i)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $fatal(1, "Run aborted on timeout");
        end
    end

    //------------------------------
    // Master side stimulus
    //------------------------------
    task automatic set_resp_ready(input logic is_wr, input logic lvl);
        if (is_wr)
            mst_req.bready = lvl;
        else
            mst_req.rready = lvl;
    endtask

    // Competing request to a neighbouring port in the same direction
    task automatic offer_request(input vec_t v, input logic lvl);
        logic [31:0] addr;
        addr = v.addr ^ (32'h1 << axi_dist_pkg::SEL_LSB);
        if (v.wr)
        begin
            mst_req.awaddr  = addr;
            mst_req.awvalid = lvl;
            mst_req.wvalid  = lvl;
        end
        else
        begin
            mst_req.araddr  = addr;
            mst_req.arvalid = lvl;
        end
    endtask

    // Called on a falling edge, returns after the response handshake
    task automatic take_response(input vec_t v, output logic [31:0] data,
                                 output logic [1:0] code);
        logic valid;
        valid = 1'b0;
        set_resp_ready(v.wr, v.rdy_dly == 2'd0);
        while (!valid)
        begin
            @(posedge clk_i);
            valid = v.wr ? mst_resp.bvalid : mst_resp.rvalid;
        end
        code = v.wr ? mst_resp.bresp : mst_resp.rresp;
        data = mst_resp.rdata;
        // Response held while the master stalls with another request on offer
        for (int i = 1; i <= v.rdy_dly; i++)
        begin
            @(negedge clk_i);
            if (i == 1)
                offer_request(v, 1'b1);
            if (i == v.rdy_dly)
                set_resp_ready(v.wr, 1'b1);
            @(posedge clk_i);
            check_value(v.wr ? mst_resp.bvalid : mst_resp.rvalid, 32'h1, "response valid held");
            check_value(v.wr ? mst_resp.bresp : mst_resp.rresp, code, "response code held");
            check_value(mst_resp.rdata, data, "read data held");
            check_value(v.wr ? {mst_resp.awready, mst_resp.wready} : {1'b0, mst_resp.arready},
                        32'h0, "request ready while a response is pending");
        end
        @(negedge clk_i);
        offer_request(v, 1'b0);
        set_resp_ready(v.wr, 1'b0);
        @(posedge clk_i);
        check_value(v.wr ? mst_resp.bvalid : mst_resp.rvalid, 32'h0, "single response");
    endtask

    task automatic run_write(input vec_t v, output logic [1:0] code);
        logic        aw_got;
        logic        w_got;
        int          cyc;
        logic [31:0] unused;
        aw_got = 1'b0;
        w_got  = 1'b0;
        cyc    = 0;
        @(negedge clk_i);
        cur_port        = v.addr[axi_dist_pkg::SEL_LSB +: axi_dist_pkg::PORT_W];
        mst_req.awaddr  = v.addr;
        mst_req.wdata   = v.data;
        mst_req.wstrb   = v.strb;
        mst_req.awvalid = (v.order != ORD_DATA);
        mst_req.wvalid  = (v.order != ORD_ADDR);
        while (!(aw_got && w_got))
        begin
            @(posedge clk_i);
            if (mst_req.awvalid && mst_resp.awready)
                aw_got = 1'b1;
            if (mst_req.wvalid && mst_resp.wready)
                w_got = 1'b1;
            @(negedge clk_i);
            cyc++;
            // Data first holds the address back for two cycles
            mst_req.awvalid = !aw_got && ((v.order != ORD_DATA) || (cyc >= 2));
            mst_req.wvalid  = !w_got && ((v.order != ORD_ADDR) || aw_got);
        end
        take_response(v, unused, code);
    endtask

    task automatic run_read(input vec_t v, output logic [31:0] data, output logic [1:0] code);
        logic ar_got;
        ar_got = 1'b0;
        @(negedge clk_i);
        cur_port        = v.addr[axi_dist_pkg::SEL_LSB +: axi_dist_pkg::PORT_W];
        mst_req.araddr  = v.addr;
        mst_req.arvalid = 1'b1;
        while (!ar_got)
        begin
            @(posedge clk_i);
            if (mst_resp.arready)
                ar_got = 1'b1;
            @(negedge clk_i);
            mst_req.arvalid = !ar_got;
        end
        take_response(v, data, code);
    endtask

    //------------------------------
    // Main sequence
    //------------------------------
    initial
    begin
        logic [31:0] rd_data;
        logic [1:0]  rsp_code;
        void'($urandom(6));
        mst_req  = '0;
        cur_port = '0;
        rst_i    = 1'b1;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // Idle state right after reset
        @(posedge clk_i);
        check_value(mst_resp.bvalid, 32'h0, "bvalid after reset");
        check_value(mst_resp.rvalid, 32'h0, "rvalid after reset");
        for (int k = 0; k < axi_dist_pkg::NUM_PORTS; k++)
            check_value({slv_req[k].awvalid, slv_req[k].wvalid, slv_req[k].arvalid},
                        32'h0, $sformatf("slave %0d valid after reset", k));

        for (int n = 0; n < NUM_VEC; n++)
        begin
            if (vectors[n].wr)
            begin
                run_write(vectors[n], rsp_code);
            end
            else
            begin
                run_read(vectors[n], rd_data, rsp_code);
                check_value(rd_data, vectors[n].exp_data, $sformatf("entry %0d read data", n));
            end
            check_value(rsp_code, vectors[n].exp_resp, $sformatf("entry %0d response", n));
        end

        $display("Verification passed");
        $finish;
    end

endmodule

// File: verilog.f
hw/axi_dist_pkg.sv
hw/axi_wr_join.sv
hw/axi_wr_route.sv
hw/axi_rd_route.sv
hw/axi_resp_return.sv
hw/axi4lite_dist.sv
testbench/axi_slave_model.sv
testbench/tb_axi4lite_dist.sv
